/* logic/chess_pkg.sv */
package chess_pkg;

    typedef logic [5:0] square_t;
    typedef logic [2:0] coord3_t;

    typedef enum logic [2:0] {
        EMPTY  = 3'd0,
        PAWN   = 3'd1,
        BISHOP = 3'd2,
        KNIGHT = 3'd3,
        ROOK   = 3'd4,
        QUEEN  = 3'd5,
        KING   = 3'd6
    } piece_kind_t;

    typedef enum logic {
        WHITE = 1'b0,
        BLACK = 1'b1
    } side_t;

    typedef struct packed {
        side_t       side;
        piece_kind_t kind;
    } piece_t;

    typedef piece_t [63:0] board_t;

    typedef struct packed {
        logic    valid;
        square_t from_sq;
        square_t to_sq;
    } move_req_t;

    typedef struct packed {
        logic    valid;
        square_t square;
    } select_t;

    // back rank by column, king sits on column 3
    localparam piece_kind_t BACK_RANK [8] = '{ROOK, KNIGHT, BISHOP, KING,
                                              QUEEN, BISHOP, KNIGHT, ROOK};

    // black on rows 0 and 1, white on rows 6 and 7
    function automatic board_t opening_layout();
        board_t b;
        for (int sq = 0; sq < 64; sq++)
        begin
            b[sq].side = (sq >= 48) ? WHITE : BLACK;
            if (sq < 8 || sq >= 56)
                b[sq].kind = BACK_RANK[sq % 8];
            else if (sq < 16 || sq >= 48)
                b[sq].kind = PAWN;
            else
                b[sq].kind = EMPTY;
        end
        return b;
    endfunction

    localparam board_t OPENING = opening_layout();

    // bit row*8+col of the 8x8 cell, row 0 at the top
    localparam logic [63:0] GLYPH [8] = '{
        64'h0000_0000_0000_0000,
        64'h7E18_1818_3C3C_1800,   // pawn
        64'h7E3C_7E6E_5E3C_1800,   // bishop
        64'h7E38_727E_7A3C_0800,   // knight
        64'h7E3C_1818_7E7E_5A00,   // rook
        64'h7E00_3C5A_5A7E_0000,   // queen
        64'h7E3C_7E5A_5A00_5A00,   // king
        64'h0000_0000_0000_0000
    };

    // second player sees the board turned by half a turn
    function automatic square_t view_square(coord3_t row, coord3_t col, side_t player);
        square_t sq;
        sq = {row, col};
        return (player == BLACK) ? 6'd63 - sq : sq;
    endfunction

endpackage

/* logic/oled_pkg.sv */
package oled_pkg;

    localparam int SCREEN_W = 96;
    localparam int SCREEN_H = 64;
    localparam int BOARD_X0 = 16;
    localparam int CELL     = 8;
    localparam int BOARD_X1 = BOARD_X0 + 8 * CELL - 1;

    typedef logic [12:0] pix_index_t;
    typedef logic [6:0]  pix_coord_t;
    typedef logic [15:0] rgb565_t;

    // rgb565 palette
    localparam rgb565_t WHITE_SQ    = 16'b11111_111111_11111;
    localparam rgb565_t BLACK_SQ    = 16'b10010_010011_00010;   // brown
    localparam rgb565_t WHITE_PIECE = 16'b11011_011101_10001;   // pink
    localparam rgb565_t BLACK_PIECE = 16'b00000_000000_00000;
    localparam rgb565_t MARGIN      = 16'b00000_000000_00000;
    localparam rgb565_t CURSOR_FILL = 16'b01111_110111_10111;   // light blue
    localparam rgb565_t CURSOR_EDGE = 16'b00000_000000_00000;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        pix_index_t adr;
    } wb_req_t;

    typedef struct packed {
        rgb565_t dat;
        logic    ack;
    } wb_rsp_t;

    typedef struct packed {
        pix_coord_t x;
        pix_coord_t y;
        logic       left;
    } mouse_t;

endpackage

/* logic/board_ram.sv */
`timescale 1ns/1ps

module board_ram (
    input  logic               clock,
    input  chess_pkg::square_t rd_sq,
    output chess_pkg::piece_t  rd_piece,
    input  logic               wr_en,
    input  chess_pkg::square_t wr_sq,
    input  chess_pkg::piece_t  wr_piece
);
    import chess_pkg::*;

    // one entry per square, row*8+col
    piece_t squares [64];

    always_ff @(posedge clock)
    begin
        if (wr_en)
        begin
            squares[wr_sq] <= wr_piece;
        end
        // registered read, old data on a same-address write
        rd_piece <= squares[rd_sq];
    end

endmodule

/* logic/board_init_counter.sv */
`timescale 1ns/1ps

module board_init_counter (
    input  logic               clock,
    input  logic               rst_n,
    output logic               init_we,
    output chess_pkg::square_t init_sq,
    output chess_pkg::piece_t  init_piece,
    output logic               init_done
);
    import chess_pkg::*;

    square_t sq_cnt;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            sq_cnt    <= '0;
            init_done <= 1'b0;
        end
        else if (!init_done)
        begin
            sq_cnt <= sq_cnt + 6'd1;
            // last square written this cycle
            if (sq_cnt == 6'd63)
            begin
                init_done <= 1'b1;
            end
        end
    end

    assign init_we    = !init_done;
    assign init_sq    = sq_cnt;
    assign init_piece = OPENING[sq_cnt];

endmodule

/* logic/render_fsm.sv */
`timescale 1ns/1ps

module render_fsm (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 init_done,
    input  oled_pkg::wb_req_t    wb_req,
    output logic                 ack,
    input  chess_pkg::move_req_t move,
    output logic                 move_ready,
    output logic                 pix_latch,
    input  chess_pkg::square_t   pixel_sq,
    output chess_pkg::square_t   rd_sq,
    input  chess_pkg::piece_t    rd_piece,
    output logic                 wr_en,
    output chess_pkg::square_t   wr_sq,
    output chess_pkg::piece_t    wr_piece,
    output logic                 shade_en
);
    import chess_pkg::*;

    typedef enum logic [3:0] {
        INIT, IDLE, LATCH, READ, SHADE, ACK, MV_READ, MV_PLACE, MV_CLEAR
    } state_t;

    localparam piece_t NO_PIECE = '{side: BLACK, kind: EMPTY};

    state_t  state;
    state_t  state_nxt;
    square_t mv_from;
    square_t mv_to;
    logic    pix_req;
    logic    move_take;

    assign pix_req   = wb_req.cyc && wb_req.stb;
    assign move_take = move.valid && move_ready;

    ////////////////////
    // next state
    ////////////////////

    always_comb
    begin
        state_nxt = state;
        case (state)
            INIT:     if (init_done) state_nxt = IDLE;
            // pixel reads win over moves
            IDLE:
            begin
                if (pix_req)
                    state_nxt = LATCH;
                else if (move_take)
                    state_nxt = MV_READ;
            end
            LATCH:    state_nxt = READ;
            READ:     state_nxt = SHADE;
            SHADE:    state_nxt = ACK;
            ACK:      state_nxt = IDLE;
            MV_READ:  state_nxt = MV_PLACE;
            MV_PLACE: state_nxt = MV_CLEAR;
            MV_CLEAR: state_nxt = IDLE;
            default:  state_nxt = INIT;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n)
            state <= INIT;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clock)
    begin
        if (move_take)
        begin
            mv_from <= move.from_sq;
            mv_to   <= move.to_sq;
        end
    end

    ////////////////////
    // outputs
    ////////////////////

    assign move_ready = (state == IDLE) && init_done && !pix_req;
    assign ack        = (state == ACK);
    assign pix_latch  = (state == LATCH);
    assign shade_en   = (state == SHADE);

    // source square only while fetching the moving piece
    assign rd_sq = (state == MV_READ) ? mv_from : pixel_sq;

    assign wr_en    = (state == MV_PLACE) || (state == MV_CLEAR);
    assign wr_sq    = (state == MV_PLACE) ? mv_to : mv_from;
    assign wr_piece = (state == MV_PLACE) ? rd_piece : NO_PIECE;

endmodule

/* logic/pixel_shader.sv */
`timescale 1ns/1ps

module pixel_shader (
    input  logic                 clock,
    input  logic                 pix_latch,
    input  oled_pkg::pix_index_t adr,
    input  chess_pkg::side_t     player,
    input  oled_pkg::mouse_t     mouse,
    input  logic                 shade_en,
    output chess_pkg::square_t   pixel_sq,
    input  chess_pkg::piece_t    piece,
    output oled_pkg::rgb565_t    colour
);
    import chess_pkg::*;
    import oled_pkg::*;

    pix_index_t        idx_q;
    pix_coord_t        px;
    pix_coord_t        py;
    coord3_t           scr_row;
    coord3_t           scr_col;
    coord3_t           cell_row;
    coord3_t           cell_col;
    logic signed [7:0] dx;
    logic signed [7:0] dy;
    logic              dx_zero;
    logic              dy_zero;
    logic              dx_one;
    logic              dy_one;
    logic              on_cursor;
    logic              on_edge;
    logic              in_margin;
    logic              on_glyph;
    rgb565_t           piece_colour;
    rgb565_t           sq_colour;

    always_ff @(posedge clock)
    begin
        if (pix_latch)
            idx_q <= adr;
    end

    ////////////////////
    // screen geometry
    ////////////////////

    assign px = pix_coord_t'(idx_q % SCREEN_W);
    assign py = pix_coord_t'(idx_q / SCREEN_W);

    // column is meaningless in the margin, margin wins there
    assign scr_col  = coord3_t'((px - BOARD_X0) / CELL);
    assign scr_row  = coord3_t'(py / CELL);
    assign cell_col = coord3_t'(px % CELL);
    assign cell_row = coord3_t'(py % CELL);

    assign pixel_sq = view_square(scr_row, scr_col, player);

    ////////////////////
    // cursor overlay
    ////////////////////

    assign dx = $signed({1'b0, px}) - $signed({1'b0, mouse.x});
    assign dy = $signed({1'b0, py}) - $signed({1'b0, mouse.y});

    assign dx_zero = (dx == 8'sd0);
    assign dy_zero = (dy == 8'sd0);
    assign dx_one  = (dx == 8'sd1) || (dx == -8'sd1);
    assign dy_one  = (dy == 8'sd1) || (dy == -8'sd1);

    // plus shape, then the four corners around it
    assign on_cursor = (dx_zero && (dy_zero || dy_one)) || (dy_zero && dx_one);
    assign on_edge   = dx_one && dy_one;

    ////////////////////
    // board and pieces
    ////////////////////

    assign in_margin    = (px < BOARD_X0) || (px > BOARD_X1);
    assign on_glyph     = GLYPH[piece.kind][{cell_row, cell_col}];
    assign piece_colour = (piece.side == WHITE) ? WHITE_PIECE : BLACK_PIECE;
    // even row+col is a light square
    assign sq_colour    = (scr_row[0] ^ scr_col[0]) ? BLACK_SQ : WHITE_SQ;

    always_ff @(posedge clock)
    begin
        if (shade_en)
        begin
            if (on_cursor)
                colour <= CURSOR_FILL;
            else if (on_edge)
                colour <= CURSOR_EDGE;
            else if (in_margin)
                colour <= MARGIN;
            else if (on_glyph)
                colour <= piece_colour;
            else
                colour <= sq_colour;
        end
    end

endmodule

/* logic/click_decoder.sv */
`timescale 1ns/1ps

module click_decoder (
    input  logic               clock,
    input  logic               rst_n,
    input  chess_pkg::side_t   player,
    input  oled_pkg::mouse_t   mouse,
    output chess_pkg::select_t select
);
    import chess_pkg::*;
    import oled_pkg::*;

    logic    left_q;
    logic    press;
    logic    on_board;
    coord3_t col;
    coord3_t row;

    // only the first sample of a held button counts
    assign press    = mouse.left && !left_q;
    assign on_board = (mouse.x >= BOARD_X0) && (mouse.x <= BOARD_X1) && (mouse.y < SCREEN_H);

    assign col = coord3_t'((mouse.x - BOARD_X0) / CELL);
    assign row = coord3_t'(mouse.y / CELL);

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            left_q       <= 1'b0;
            select.valid <= 1'b0;
        end
        else
        begin
            left_q       <= mouse.left;
            select.valid <= press && on_board;
        end
        if (press)
            select.square <= view_square(row, col, player);
    end

endmodule

/* logic/board_art.sv */
`timescale 1ns/1ps

module board_art (
    input  logic                 clock,
    input  logic                 rst_n,
    input  chess_pkg::side_t     player,
    input  oled_pkg::wb_req_t    wb_req,
    output oled_pkg::wb_rsp_t    wb_rsp,
    input  chess_pkg::move_req_t move,
    output logic                 move_ready,
    input  oled_pkg::mouse_t     mouse,
    output chess_pkg::select_t   select
);
    import chess_pkg::*;
    import oled_pkg::*;

    square_t rd_sq;
    square_t pixel_sq;
    square_t init_sq;
    square_t fsm_wr_sq;
    square_t ram_wr_sq;
    piece_t  rd_piece;
    piece_t  init_piece;
    piece_t  fsm_wr_piece;
    piece_t  ram_wr_piece;
    logic    init_we;
    logic    init_done;
    logic    fsm_wr_en;
    logic    ram_wr_en;
    logic    pix_latch;
    logic    shade_en;
    logic    ack;
    rgb565_t colour;

    ////////////////////
    // board memory
    ////////////////////

    // counter owns the write port until the layout is loaded
    assign ram_wr_en    = init_done ? fsm_wr_en : init_we;
    assign ram_wr_sq    = init_done ? fsm_wr_sq : init_sq;
    assign ram_wr_piece = init_done ? fsm_wr_piece : init_piece;

    board_init_counter u_init (
        .clock(clock), .rst_n(rst_n), .init_we(init_we),
        .init_sq(init_sq), .init_piece(init_piece), .init_done(init_done)
    );

    board_ram u_ram (
        .clock(clock), .rd_sq(rd_sq), .rd_piece(rd_piece),
        .wr_en(ram_wr_en), .wr_sq(ram_wr_sq), .wr_piece(ram_wr_piece)
    );

    ////////////////////
    // control and pixels
    ////////////////////

    render_fsm u_fsm (
        .clock(clock), .rst_n(rst_n), .init_done(init_done),
        .wb_req(wb_req), .ack(ack), .move(move), .move_ready(move_ready),
        .pix_latch(pix_latch), .pixel_sq(pixel_sq), .rd_sq(rd_sq),
        .rd_piece(rd_piece), .wr_en(fsm_wr_en), .wr_sq(fsm_wr_sq),
        .wr_piece(fsm_wr_piece), .shade_en(shade_en)
    );

    pixel_shader u_shader (
        .clock(clock), .pix_latch(pix_latch), .adr(wb_req.adr),
        .player(player), .mouse(mouse), .shade_en(shade_en),
        .pixel_sq(pixel_sq), .piece(rd_piece), .colour(colour)
    );

    assign wb_rsp = '{dat: colour, ack: ack};

    click_decoder u_click (
        .clock(clock), .rst_n(rst_n), .player(player),
        .mouse(mouse), .select(select)
    );

endmodule

/* test/board_art_sva.sv */
`timescale 1ns/1ps

module board_art_sva (
    input logic              clock,
    input logic              rst_n,
    input oled_pkg::wb_req_t wb_req,
    input oled_pkg::wb_rsp_t wb_rsp,
    input logic              move_ready,
    input logic              pix_latch,
    input logic              init_done
);

    a_ack_single: assert property (@(posedge clock) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack held for more than one cycle");

    a_ack_needs_req: assert property (@(posedge clock) disable iff (!rst_n)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else $error("ack without cyc and stb");

    // latch follows the idle stb, ack three cycles after the stb
    a_ack_latency: assert property (@(posedge clock) disable iff (!rst_n)
        pix_latch |=> !wb_rsp.ack ##1 !wb_rsp.ack ##1 wb_rsp.ack)
        else $error("pixel read not acked three cycles after stb");

    a_no_ack_in_init: assert property (@(posedge clock) disable iff (!rst_n)
        !init_done |-> !wb_rsp.ack)
        else $error("ack during board initialisation");

    a_ready_off_at_ack: assert property (@(posedge clock) disable iff (!rst_n)
        wb_rsp.ack |-> !move_ready)
        else $error("move_ready high together with ack");

endmodule

/* test/board_checker.sv */
`timescale 1ns/1ps

module board_checker (
    input  logic                 clock,
    input  logic                 rst_n,
    input  chess_pkg::side_t     player,
    input  oled_pkg::wb_req_t    wb_req,
    input  oled_pkg::wb_rsp_t    wb_rsp,
    input  chess_pkg::move_req_t move,
    input  logic                 move_ready,
    input  oled_pkg::mouse_t     mouse,
    input  chess_pkg::select_t   select,
    output int                   pix_errors,
    output int                   sel_errors,
    output int                   lat_errors,
    output int                   reads_checked
);
    import chess_pkg::*;
    import oled_pkg::*;

    piece_t     board [64];
    logic       pending;
    logic       timed;
    int         wait_cnt;
    int         mv_busy;
    pix_index_t cap_adr;
    side_t      cap_player;
    mouse_t     cap_mouse;
    logic       prev_ready;
    logic       prev_left;
    logic       exp_valid;
    square_t    exp_square;

    // expected pixel colour from the screen rules
    function automatic rgb565_t expect_colour(pix_index_t a, side_t pl, mouse_t m);
        int     x;
        int     y;
        int     adx;
        int     ady;
        int     row;
        int     col;
        int     sq;
        piece_t p;
        x = int'(a) % SCREEN_W;
        y = int'(a) / SCREEN_W;
        adx = (x > int'(m.x)) ? x - int'(m.x) : int'(m.x) - x;
        ady = (y > int'(m.y)) ? y - int'(m.y) : int'(m.y) - y;
        if ((adx == 0 && ady <= 1) || (ady == 0 && adx <= 1))
            return CURSOR_FILL;
        if (adx == 1 && ady == 1)
            return CURSOR_EDGE;
        if (x < 16 || x > 79)
            return MARGIN;
        col = (x - BOARD_X0) / CELL;
        row = y / CELL;
        sq = row * 8 + col;
        if (pl == BLACK)
            sq = 63 - sq;
        p = board[sq];
        if (GLYPH[p.kind][(y % CELL) * 8 + (x % CELL)])
            return (p.side == WHITE) ? WHITE_PIECE : BLACK_PIECE;
        return ((row + col) % 2 == 0) ? WHITE_SQ : BLACK_SQ;
    endfunction

    initial
    begin
        for (int i = 0; i < 64; i++)
            board[i] = OPENING[i];
        pix_errors    = 0;
        sel_errors    = 0;
        lat_errors    = 0;
        reads_checked = 0;
    end

    always @(posedge clock)
    begin
        if (!rst_n)
        begin
            pending    = 1'b0;
            mv_busy    = 0;
            prev_ready = 1'b0;
            prev_left  = 1'b0;
            exp_valid  = 1'b0;
        end
        else
        begin
            // no move may start while a read or a move is in flight
            if ((pending || mv_busy > 0) && move_ready)
            begin
                lat_errors++;
                $display("ERROR: move_ready expected %h got %h", 1'b0, move_ready);
            end
            if (mv_busy > 0)
                mv_busy--;

            ////////////////////
            // pixel reads
            ////////////////////
            if (pending)
            begin
                wait_cnt++;
                if (wb_rsp.ack)
                begin
                    reads_checked++;
                    if (wb_rsp.dat !== expect_colour(cap_adr, cap_player, cap_mouse))
                    begin
                        pix_errors++;
                        $display("ERROR: wb_rsp.dat adr=%h expected %h got %h", cap_adr,
                                 expect_colour(cap_adr, cap_player, cap_mouse), wb_rsp.dat);
                    end
                    // edge of stb to edge of ack is four samples
                    if (timed && wait_cnt != 4)
                    begin
                        lat_errors++;
                        $display("read of address %h acked after %0d cycles instead of 3",
                                 cap_adr, wait_cnt - 1);
                    end
                    if (!timed && wait_cnt < 64)
                    begin
                        lat_errors++;
                        $display("read of address %h acked before the board was loaded",
                                 cap_adr);
                    end
                    pending = 1'b0;
                end
            end
            else if (wb_rsp.ack)
            begin
                lat_errors++;
                $display("ack seen with no read outstanding");
            end
            else if (wb_req.cyc && wb_req.stb)
            begin
                pending    = 1'b1;
                timed      = prev_ready;
                wait_cnt   = 0;
                cap_adr    = wb_req.adr;
                cap_player = player;
                cap_mouse  = mouse;
            end

            // accepted move
            if (move.valid && move_ready)
            begin
                board[move.to_sq]   = board[move.from_sq];
                board[move.from_sq] = '{side: BLACK, kind: EMPTY};
                mv_busy             = 3;
            end

            ////////////////////
            // click selection
            ////////////////////
            if (select.valid !== exp_valid)
            begin
                sel_errors++;
                $display("ERROR: select.valid expected %h got %h", exp_valid, select.valid);
            end
            else if (exp_valid && select.square !== exp_square)
            begin
                sel_errors++;
                $display("ERROR: select.square expected %h got %h", exp_square, select.square);
            end
            exp_valid = mouse.left && !prev_left && mouse.x >= 16 && mouse.x <= 79
                        && mouse.y < 64;
            exp_square = square_t'((mouse.y / 8) * 8 + (mouse.x - 16) / 8);
            if (player == BLACK)
                exp_square = 6'd63 - exp_square;
            prev_left  = mouse.left;
            prev_ready = move_ready;
        end
    end

endmodule

/* test/tb_board_art.sv */
`timescale 1ns/1ps

module tb_board_art;
    import chess_pkg::*;
    import oled_pkg::*;

    typedef enum logic [1:0] {
        OP_READ,
        OP_MOVE,
        OP_CLICK
    } op_t;

    typedef struct packed {
        op_t        op;
        pix_index_t a;
        square_t    b;
        side_t      pl;
        logic       fixed_mouse;
        pix_coord_t mx;
        pix_coord_t my;
    } row_t;

    localparam int N_ROWS      = 31;
    localparam int WATCHDOG_NS = (N_ROWS * 20 + 100 + 5) * 4;

    function automatic row_t read_row(int x, int y, side_t pl);
        return '{OP_READ, pix_index_t'(y * SCREEN_W + x), 6'd0, pl, 1'b0, 7'd0, 7'd0};
    endfunction

    function automatic row_t cursor_row(int x, int y, int mx, int my);
        return '{OP_READ, pix_index_t'(y * SCREEN_W + x), 6'd0, WHITE, 1'b1,
                 pix_coord_t'(mx), pix_coord_t'(my)};
    endfunction

    function automatic row_t move_row(int from_sq, int to_sq);
        return '{OP_MOVE, pix_index_t'(from_sq), square_t'(to_sq), WHITE, 1'b0, 7'd0, 7'd0};
    endfunction

    function automatic row_t click_row(int x, int y, side_t pl);
        return '{OP_CLICK, 13'd0, 6'd0, pl, 1'b1, pix_coord_t'(x), pix_coord_t'(y)};
    endfunction

    // first read lands during board loading
    localparam row_t ROWS [N_ROWS] = '{
        read_row(19, 3, WHITE), read_row(20, 5, WHITE), read_row(28, 4, WHITE),
        read_row(44, 12, WHITE), read_row(52, 30, WHITE), read_row(60, 50, WHITE),
        read_row(76, 60, WHITE), read_row(23, 57, WHITE),
        read_row(19, 3, BLACK), read_row(44, 12, BLACK), read_row(60, 50, BLACK),
        read_row(76, 60, BLACK),
        read_row(5, 20, WHITE), read_row(90, 40, BLACK),
        cursor_row(20, 4, 20, 4), cursor_row(21, 4, 20, 4), cursor_row(20, 3, 20, 4),
        cursor_row(19, 51, 20, 52), cursor_row(21, 53, 20, 52),
        move_row(8, 24), read_row(19, 27, WHITE), read_row(19, 11, WHITE),
        move_row(52, 36), read_row(51, 34, WHITE), read_row(51, 50, WHITE),
        read_row(51, 34, BLACK),
        click_row(30, 20, WHITE), click_row(30, 20, BLACK), click_row(8, 20, WHITE),
        click_row(85, 5, BLACK), click_row(79, 63, WHITE)
    };

    logic      clock;
    logic      rst_n;
    side_t     player;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;
    move_req_t move;
    logic      move_ready;
    mouse_t    mouse;
    select_t   select;
    int        pix_errors;
    int        sel_errors;
    int        lat_errors;
    int        reads_checked;

    board_art u_board_art (
        .clock(clock), .rst_n(rst_n), .player(player), .wb_req(wb_req),
        .wb_rsp(wb_rsp), .move(move), .move_ready(move_ready),
        .mouse(mouse), .select(select)
    );

    board_checker u_checker (
        .clock(clock), .rst_n(rst_n), .player(player), .wb_req(wb_req),
        .wb_rsp(wb_rsp), .move(move), .move_ready(move_ready), .mouse(mouse),
        .select(select), .pix_errors(pix_errors), .sel_errors(sel_errors),
        .lat_errors(lat_errors), .reads_checked(reads_checked)
    );

    bind board_art board_art_sva u_sva (
        .clock(clock), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp),
        .move_ready(move_ready), .pix_latch(pix_latch), .init_done(init_done)
    );

    initial
        clock = 1'b0;

    always #2 clock = ~clock;

    task automatic apply_row(input row_t r);
        mouse_t m;
        if (r.fixed_mouse)
            m = '{x: r.mx, y: r.my, left: 1'b0};
        else
            // parked below the screen, far from any pixel
            m = '{x: pix_coord_t'($urandom % 96), y: pix_coord_t'(70 + $urandom % 58),
                  left: 1'b0};
        @(negedge clock);
        player = r.pl;
        mouse  = m;
        case (r.op)
            OP_READ:
            begin
                wb_req = '{cyc: 1'b1, stb: 1'b1, adr: r.a};
                do @(posedge clock); while (!wb_rsp.ack);
                @(negedge clock);
                wb_req = '0;
            end
            OP_MOVE:
            begin
                move = '{valid: 1'b1, from_sq: r.a[5:0], to_sq: r.b};
                do @(posedge clock); while (!move_ready);
                @(negedge clock);
                move = '0;
                do @(posedge clock); while (!move_ready);
            end
            default:
            begin
                mouse.left = 1'b1;
                @(negedge clock);
                mouse.left = 1'b0;
                repeat (3) @(negedge clock);
            end
        endcase
    endtask

    initial
    begin
        int total;
        void'($urandom(84));
        rst_n  = 1'b0;
        player = WHITE;
        wb_req = '0;
        move   = '0;
        mouse  = '{x: 7'd0, y: 7'd100, left: 1'b0};
        repeat (5) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        for (int i = 0; i < N_ROWS; i++)
            apply_row(ROWS[i]);
        repeat (5) @(negedge clock);

        total = pix_errors + sel_errors + lat_errors;
        $display("errors: pixel %0d, select %0d, timing %0d; reads checked %0d",
                 pix_errors, sel_errors, lat_errors, reads_checked);
        if (total == 0 && reads_checked > 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    // watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("simulation timed out, the DUT stopped answering");
        $display("Some tests failed");
        $finish;
    end

endmodule

/* list.f */
logic/chess_pkg.sv
logic/oled_pkg.sv
logic/board_ram.sv
logic/board_init_counter.sv
logic/render_fsm.sv
logic/pixel_shader.sv
logic/click_decoder.sv
logic/board_art.sv
test/board_art_sva.sv
test/board_checker.sv
test/tb_board_art.sv

/* run.sh */
#!/bin/bash
# build and run the board_art testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board_art \
    --Mdir obj_dir -o sim_board_art \
    -f list.f

./obj_dir/sim_board_art | tee sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
